// ==== filelist.f ====
poller_cfg_pkg.sv
poller_types_pkg.sv
flow_queue.sv
flow_table.sv
poll_admission.sv
msg_ptr_poller_ctrl.sv
msg_ptr_poller_datapath.sv
msg_ptr_poller_top.sv
tb_msg_ptr_poller.sv

// ==== flow_queue.sv ====
`timescale 1ns/1ns

module flow_queue #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_val,
    input  payload_t wr_data,
    output logic     wr_rdy,
    input  logic     rd_req_val,
    output logic     empty,
    output payload_t rd_data
);
    import poller_cfg_pkg::*;

    payload_t          mem [queue_depth];
    logic [qptr_w-1:0] wr_ptr;
    logic [qptr_w-1:0] rd_ptr;
    logic [qcnt_w-1:0] count;
    logic              push;
    logic              pop;

    assign wr_rdy = (count != qcnt_w'(queue_depth));
    assign empty = (count == '0);
    assign push = wr_val & wr_rdy;
    assign pop = rd_req_val & ~empty;
    assign rd_data = mem[rd_ptr];   // the head is always visible.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // the pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== flow_table.sv ====
`timescale 1ns/1ns

module flow_table #(
    parameter type entry_t = logic [7:0]
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_val,
    input  poller_types_pkg::flowid_t wr_flowid,
    input  entry_t                    wr_data,
    input  logic                      rd_req_val,
    input  poller_types_pkg::flowid_t rd_req_flowid,
    output logic                      rd_req_rdy,
    output logic                      rd_resp_val,
    input  logic                      rd_resp_rdy,
    output entry_t                    rd_resp_data
);
    import poller_cfg_pkg::*;

    entry_t mem [num_flows];
    logic   rd_fire;

    // a new request waits while a response is still held.
    assign rd_req_rdy = ~rd_resp_val;
    assign rd_fire = rd_req_val & rd_req_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_flows; i++) begin
                mem[i] <= '0;
            end
            rd_resp_val <= 1'b0;
        end
        else begin
            if (wr_val) begin
                mem[wr_flowid] <= wr_data;
            end
            if (rd_fire) begin
                rd_resp_val <= 1'b1;
            end
            else if (rd_resp_rdy) begin
                rd_resp_val <= 1'b0;
            end
        end
    end

    // a read that meets a write to the same entry sees the old value.
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_resp_data <= mem[rd_req_flowid];
        end
    end

endmodule

// ==== msg_ptr_poller_ctrl.sv ====
`timescale 1ns/1ns

module msg_ptr_poller_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic q_empty,
    output logic q_rd_req_val,
    output logic req_mem_rd_req_val,
    input  logic req_mem_rd_req_rdy,
    input  logic req_mem_rd_resp_val,
    output logic req_mem_rd_resp_rdy,
    output logic base_idx_rd_req_val,
    input  logic base_idx_rd_req_rdy,
    input  logic base_idx_rd_resp_val,
    output logic base_idx_rd_resp_rdy,
    output logic end_idx_rd_req_val,
    input  logic end_idx_rd_req_rdy,
    input  logic end_idx_rd_resp_val,
    output logic end_idx_rd_resp_rdy,
    output logic base_buf_rd_req_val,
    input  logic base_buf_rd_req_rdy,
    input  logic base_buf_rd_resp_val,
    output logic base_buf_rd_resp_rdy,
    output logic requeue_val,
    input  logic requeue_rdy,
    output logic notif_val,
    input  logic notif_rdy,
    output logic clear_val,
    input  logic msg_satis,
    output logic store_flowid,
    output logic store_req_data,
    output logic store_idxs,
    output logic store_buf
);
    import poller_types_pkg::*;

    poll_state_e state_reg;
    poll_state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ready;
        end
        else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        q_rd_req_val = 1'b0;
        req_mem_rd_req_val = 1'b0;
        req_mem_rd_resp_rdy = 1'b0;
        base_idx_rd_req_val = 1'b0;
        base_idx_rd_resp_rdy = 1'b0;
        end_idx_rd_req_val = 1'b0;
        end_idx_rd_resp_rdy = 1'b0;
        base_buf_rd_req_val = 1'b0;
        base_buf_rd_resp_rdy = 1'b0;
        requeue_val = 1'b0;
        notif_val = 1'b0;
        clear_val = 1'b0;
        store_flowid = 1'b0;
        store_req_data = 1'b0;
        store_idxs = 1'b0;
        store_buf = 1'b0;
        state_next = state_reg;

        case (state_reg)
            ready: begin
                // pop the head and read its request length in one go.
                if (~q_empty & req_mem_rd_req_rdy) begin
                    q_rd_req_val = 1'b1;
                    req_mem_rd_req_val = 1'b1;
                    store_flowid = 1'b1;
                    state_next = rd_idxs;
                end
            end
            rd_idxs: begin
                if (base_idx_rd_req_rdy & end_idx_rd_req_rdy) begin
                    base_idx_rd_req_val = 1'b1;
                    end_idx_rd_req_val = 1'b1;
                    state_next = state_resp;
                end
            end
            state_resp: begin
                if (req_mem_rd_resp_val & base_idx_rd_resp_val & end_idx_rd_resp_val) begin
                    req_mem_rd_resp_rdy = 1'b1;
                    base_idx_rd_resp_rdy = 1'b1;
                    end_idx_rd_resp_rdy = 1'b1;
                    store_req_data = 1'b1;
                    store_idxs = 1'b1;
                    state_next = calc;
                end
            end
            calc: begin
                state_next = msg_satis ? buf_store_req : requeue_flow;
            end
            requeue_flow: begin
                requeue_val = 1'b1;
                if (requeue_rdy) begin
                    state_next = ready;
                end
            end
            buf_store_req: begin
                base_buf_rd_req_val = 1'b1;
                if (base_buf_rd_req_rdy) begin
                    state_next = buf_store_resp;
                end
            end
            buf_store_resp: begin
                base_buf_rd_resp_rdy = 1'b1;
                if (base_buf_rd_resp_val) begin
                    store_buf = 1'b1;
                    state_next = send_notif;
                end
            end
            send_notif: begin
                notif_val = 1'b1;
                if (notif_rdy) begin
                    clear_val = 1'b1;   // the flow goes idle again.
                    state_next = ready;
                end
            end
            default: begin
                q_rd_req_val = 'x;
                req_mem_rd_req_val = 'x;
                base_idx_rd_req_val = 'x;
                end_idx_rd_req_val = 'x;
                base_buf_rd_req_val = 'x;
                requeue_val = 'x;
                notif_val = 'x;
                clear_val = 'x;
                state_next = poll_state_e'(3'bxxx);
            end
        endcase
    end

endmodule

// ==== msg_ptr_poller_datapath.sv ====
`timescale 1ns/1ns

module msg_ptr_poller_datapath (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        store_flowid,
    input  logic                        store_req_data,
    input  logic                        store_idxs,
    input  logic                        store_buf,
    input  poller_types_pkg::flowid_t   head_flowid,
    input  poller_types_pkg::msg_len_t  req_len_data,
    input  poller_types_pkg::ring_idx_t base_idx_data,
    input  poller_types_pkg::ring_idx_t end_idx_data,
    input  poller_types_pkg::buf_addr_t buf_base_data,
    output poller_types_pkg::flowid_t   cur_flowid,
    output logic                        msg_satis,
    output poller_types_pkg::buf_addr_t notif_addr,
    output poller_types_pkg::msg_len_t  notif_len
);
    import poller_cfg_pkg::*;
    import poller_types_pkg::*;

    msg_len_t  len_reg;
    ring_idx_t base_reg;
    ring_idx_t end_reg;
    buf_addr_t buf_base_reg;
    ring_idx_t avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_flowid <= '0;
            len_reg <= '0;
            base_reg <= '0;
            end_reg <= '0;
            buf_base_reg <= '0;
        end
        else begin
            if (store_flowid) begin
                cur_flowid <= head_flowid;
            end
            if (store_req_data) begin
                len_reg <= req_len_data;
            end
            if (store_idxs) begin
                base_reg <= base_idx_data;
                end_reg <= end_idx_data;
            end
            if (store_buf) begin
                buf_base_reg <= buf_base_data;
            end
        end
    end

    assign avail = end_reg - base_reg;   // bytes in the ring, modulo 256.
    assign msg_satis = (avail >= len_reg);

    assign notif_addr = buf_base_reg + {{(addr_w - idx_w){1'b0}}, base_reg};
    assign notif_len = len_reg;

endmodule

// ==== msg_ptr_poller_top.sv ====
`timescale 1ns/1ns

module msg_ptr_poller_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_val,
    input  poller_types_pkg::flowid_t   req_flowid,
    input  poller_types_pkg::msg_len_t  req_len,
    output logic                        req_rdy,
    input  logic                        cfg_val,
    input  poller_types_pkg::flowid_t   cfg_flowid,
    input  poller_types_pkg::ring_idx_t cfg_base_idx,
    input  poller_types_pkg::buf_addr_t cfg_buf_base,
    input  logic                        end_val,
    input  poller_types_pkg::flowid_t   end_flowid,
    input  poller_types_pkg::ring_idx_t end_idx,
    output logic                        notif_val,
    output poller_types_pkg::flowid_t   notif_flowid,
    output poller_types_pkg::buf_addr_t notif_addr,
    output poller_types_pkg::msg_len_t  notif_len,
    input  logic                        notif_rdy
);
    import poller_types_pkg::*;

    logic      req_accept, q_wr_val, q_wr_rdy, q_empty, q_rd_req_val;
    flowid_t   q_wr_data, q_head, cur_flowid;
    logic      requeue_val, requeue_rdy, clear_val, msg_satis;
    logic      store_flowid, store_req_data, store_idxs, store_buf;

    logic      req_mem_rd_req_val, req_mem_rd_req_rdy, req_mem_rd_resp_val, req_mem_rd_resp_rdy;
    logic      base_idx_rd_req_val, base_idx_rd_req_rdy, base_idx_rd_resp_val, base_idx_rd_resp_rdy;
    logic      end_idx_rd_req_val, end_idx_rd_req_rdy, end_idx_rd_resp_val, end_idx_rd_resp_rdy;
    logic      base_buf_rd_req_val, base_buf_rd_req_rdy, base_buf_rd_resp_val, base_buf_rd_resp_rdy;
    msg_len_t  req_len_data;
    ring_idx_t base_idx_data, end_idx_data;
    buf_addr_t buf_base_data;

    // ============================================================
    // poll queue and admission
    // ============================================================
    poll_admission poll_admission_inst (
        .clk, .rst, .req_val, .req_flowid, .req_rdy, .req_accept,
        .requeue_val, .requeue_flowid(cur_flowid), .requeue_rdy,
        .clear_val, .clear_flowid(cur_flowid), .q_wr_val, .q_wr_data, .q_wr_rdy
    );

    flow_queue #(.payload_t(flowid_t)) flow_queue_inst (
        .clk, .rst, .wr_val(q_wr_val), .wr_data(q_wr_data), .wr_rdy(q_wr_rdy),
        .rd_req_val(q_rd_req_val), .empty(q_empty), .rd_data(q_head)
    );

    // ============================================================
    // per-flow tables
    // ============================================================
    // the request table is read by the queue head, the others by the stored flow.
    flow_table #(.entry_t(msg_len_t)) req_mem_inst (
        .clk, .rst, .wr_val(req_accept), .wr_flowid(req_flowid), .wr_data(req_len),
        .rd_req_val(req_mem_rd_req_val), .rd_req_flowid(q_head), .rd_req_rdy(req_mem_rd_req_rdy),
        .rd_resp_val(req_mem_rd_resp_val), .rd_resp_rdy(req_mem_rd_resp_rdy),
        .rd_resp_data(req_len_data)
    );

    flow_table #(.entry_t(ring_idx_t)) base_idx_inst (
        .clk, .rst, .wr_val(cfg_val), .wr_flowid(cfg_flowid), .wr_data(cfg_base_idx),
        .rd_req_val(base_idx_rd_req_val), .rd_req_flowid(cur_flowid),
        .rd_req_rdy(base_idx_rd_req_rdy), .rd_resp_val(base_idx_rd_resp_val),
        .rd_resp_rdy(base_idx_rd_resp_rdy), .rd_resp_data(base_idx_data)
    );

    flow_table #(.entry_t(ring_idx_t)) end_idx_inst (
        .clk, .rst, .wr_val(end_val), .wr_flowid(end_flowid), .wr_data(end_idx),
        .rd_req_val(end_idx_rd_req_val), .rd_req_flowid(cur_flowid),
        .rd_req_rdy(end_idx_rd_req_rdy), .rd_resp_val(end_idx_rd_resp_val),
        .rd_resp_rdy(end_idx_rd_resp_rdy), .rd_resp_data(end_idx_data)
    );

    flow_table #(.entry_t(buf_addr_t)) base_buf_inst (
        .clk, .rst, .wr_val(cfg_val), .wr_flowid(cfg_flowid), .wr_data(cfg_buf_base),
        .rd_req_val(base_buf_rd_req_val), .rd_req_flowid(cur_flowid),
        .rd_req_rdy(base_buf_rd_req_rdy), .rd_resp_val(base_buf_rd_resp_val),
        .rd_resp_rdy(base_buf_rd_resp_rdy), .rd_resp_data(buf_base_data)
    );

    // ============================================================
    // controller and datapath
    // ============================================================
    msg_ptr_poller_ctrl msg_ptr_poller_ctrl_inst (
        .clk, .rst, .q_empty, .q_rd_req_val,
        .req_mem_rd_req_val, .req_mem_rd_req_rdy, .req_mem_rd_resp_val, .req_mem_rd_resp_rdy,
        .base_idx_rd_req_val, .base_idx_rd_req_rdy, .base_idx_rd_resp_val, .base_idx_rd_resp_rdy,
        .end_idx_rd_req_val, .end_idx_rd_req_rdy, .end_idx_rd_resp_val, .end_idx_rd_resp_rdy,
        .base_buf_rd_req_val, .base_buf_rd_req_rdy, .base_buf_rd_resp_val, .base_buf_rd_resp_rdy,
        .requeue_val, .requeue_rdy, .notif_val, .notif_rdy, .clear_val, .msg_satis,
        .store_flowid, .store_req_data, .store_idxs, .store_buf
    );

    msg_ptr_poller_datapath msg_ptr_poller_datapath_inst (
        .clk, .rst, .store_flowid, .store_req_data, .store_idxs, .store_buf,
        .head_flowid(q_head), .req_len_data, .base_idx_data, .end_idx_data, .buf_base_data,
        .cur_flowid, .msg_satis, .notif_addr, .notif_len
    );

    assign notif_flowid = cur_flowid;

endmodule

// ==== poll_admission.sv ====
`timescale 1ns/1ns

module poll_admission (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_val,
    input  poller_types_pkg::flowid_t req_flowid,
    output logic                      req_rdy,
    output logic                      req_accept,
    input  logic                      requeue_val,
    input  poller_types_pkg::flowid_t requeue_flowid,
    output logic                      requeue_rdy,
    input  logic                      clear_val,
    input  poller_types_pkg::flowid_t clear_flowid,
    output logic                      q_wr_val,
    output poller_types_pkg::flowid_t q_wr_data,
    input  logic                      q_wr_rdy
);
    import poller_cfg_pkg::*;

    logic [num_flows-1:0] active;

    // ============================================================
    // queue write arbitration
    // ============================================================
    assign requeue_rdy = q_wr_rdy;   // a requeue always wins the queue.
    assign req_rdy = ~active[req_flowid] & ~requeue_val & q_wr_rdy;
    assign req_accept = req_val & req_rdy;

    assign q_wr_val = requeue_val | req_accept;
    assign q_wr_data = requeue_val ? requeue_flowid : req_flowid;

    // ============================================================
    // active flows
    // ============================================================
    // a flow stays active from its post until its notification is taken.
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= '0;
        end
        else begin
            if (req_accept) begin
                active[req_flowid] <= 1'b1;
            end
            if (clear_val) begin
                active[clear_flowid] <= 1'b0;
            end
        end
    end

endmodule

// ==== poller_cfg_pkg.sv ====
package poller_cfg_pkg;

    // ============================================================
    // flow and ring sizes
    // ============================================================
    localparam int num_flows = 8;
    localparam int flowid_w = 3;
    localparam int idx_w = 8;        // 256 byte positions per ring.
    localparam int addr_w = 16;

    // ============================================================
    // poll queue sizes
    // ============================================================
    localparam int queue_depth = num_flows;   // one slot per flow, so it never overflows.
    localparam int qptr_w = 3;
    localparam int qcnt_w = 4;

endpackage

// ==== poller_types_pkg.sv ====
package poller_types_pkg;

    typedef logic [poller_cfg_pkg::flowid_w-1:0] flowid_t;
    typedef logic [poller_cfg_pkg::idx_w-1:0]    ring_idx_t;
    typedef logic [poller_cfg_pkg::idx_w-1:0]    msg_len_t;   // requested byte count.
    typedef logic [poller_cfg_pkg::addr_w-1:0]   buf_addr_t;

    // states of the poll controller.
    typedef enum logic [2:0] {
        ready          = 3'd0,
        rd_idxs        = 3'd1,
        state_resp     = 3'd2,
        calc           = 3'd3,
        requeue_flow   = 3'd4,
        buf_store_req  = 3'd5,
        buf_store_resp = 3'd6,
        send_notif     = 3'd7
    } poll_state_e;

endpackage

// ==== tb_msg_ptr_poller.sv ====
`timescale 1ns/1ns

module tb_msg_ptr_poller;
    import poller_cfg_pkg::*;
    import poller_types_pkg::*;

    localparam int num_posts = 14;
    localparam int num_tests = 5;
    localparam int cycle_limit = num_posts * 40 + num_tests * 200;

    logic      clk;
    logic      rst;
    logic      req_val, req_rdy, cfg_val, end_val, notif_val, notif_rdy;
    flowid_t   req_flowid, cfg_flowid, end_flowid, notif_flowid;
    msg_len_t  req_len, notif_len;
    ring_idx_t cfg_base_idx, end_idx;
    buf_addr_t cfg_buf_base, notif_addr;

    // ============================================================
    // reference model
    // ============================================================
    ring_idx_t            base_m [num_flows];
    ring_idx_t            end_m [num_flows];
    buf_addr_t            bufb_m [num_flows];
    msg_len_t             len_m [num_flows];
    msg_len_t             post_len [num_flows];
    logic [num_flows-1:0] waiting_m;   // posted but still short of bytes.
    logic [26:0]          exp_q [$];   // {flow id, address, length} in arrival order.
    logic [26:0]          exp_entry;
    logic [15:0]          lfsr = 16'd72;
    int                   cycle_count = 0;
    int                   span;
    flowid_t              cur_f;
    ring_idx_t            cur_base;
    msg_len_t             cur_len;
    logic                 stall_prev;
    flowid_t              flowid_prev;
    buf_addr_t            addr_prev;
    msg_len_t             len_prev;

    msg_ptr_poller_top msg_ptr_poller_top_inst (
        .clk, .rst, .req_val, .req_flowid, .req_len, .req_rdy,
        .cfg_val, .cfg_flowid, .cfg_base_idx, .cfg_buf_base,
        .end_val, .end_flowid, .end_idx,
        .notif_val, .notif_flowid, .notif_addr, .notif_len, .notif_rdy
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr, one step per bit taken.
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic is_satisfied(input flowid_t f);
        ring_idx_t avail;
        avail = end_m[f] - base_m[f];   // wraps like the ring does.
        return avail >= len_m[f];
    endfunction

    function automatic logic [26:0] model_entry(input flowid_t f);
        buf_addr_t addr;
        addr = bufb_m[f] + {8'h00, base_m[f]};
        return {f, addr, len_m[f]};
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal;
    endtask

    task automatic report_mismatch(input string name, input int got, input int expected);
        $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, expected);
        abort_run();
    endtask

    task automatic configure_flow(input flowid_t f, input ring_idx_t base, input buf_addr_t bufb);
        @(negedge clk);
        cfg_val = 1'b1;
        cfg_flowid = f;
        cfg_base_idx = base;
        cfg_buf_base = bufb;
        @(negedge clk);
        cfg_val = 1'b0;
        base_m[f] = base;
        bufb_m[f] = bufb;
    endtask

    task automatic write_end(input flowid_t f, input ring_idx_t e);
        @(negedge clk);
        end_val = 1'b1;
        end_flowid = f;
        end_idx = e;
        @(negedge clk);
        end_val = 1'b0;
        end_m[f] = e;
        if (waiting_m[f] && is_satisfied(f)) begin
            exp_q.push_back(model_entry(f));
            waiting_m[f] = 1'b0;
        end
    endtask

    task automatic post_request(input flowid_t f, input msg_len_t len);
        logic accepted;
        @(negedge clk);
        req_val = 1'b1;
        req_flowid = f;
        req_len = len;
        do begin
            #1;
            accepted = req_rdy;   // stable until the next rising edge.
            @(negedge clk);
        end while (!accepted);
        req_val = 1'b0;
        len_m[f] = len;
        if (is_satisfied(f)) exp_q.push_back(model_entry(f));
        else waiting_m[f] = 1'b1;
    endtask

    task automatic wait_for_drain();
        while (exp_q.size() != 0 || notif_val) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic check_all_ready();
        for (int f = 0; f < num_flows; f++) begin
            @(negedge clk);
            req_flowid = flowid_t'(f);
            #1;
            assert (req_rdy) else report_mismatch("req_rdy", int'(req_rdy), 1);
            assert (!notif_val) else report_mismatch("notif_val", int'(notif_val), 0);
        end
    endtask

    // ============================================================
    // notification checks
    // ============================================================
    always @(posedge clk) begin
        if (rst) begin
            stall_prev <= 1'b0;
        end
        else begin
            if (stall_prev) begin
                assert (notif_val) else begin
                    $display("notif_val dropped at %0t while notif_rdy was low", $time);
                    abort_run();
                end
                assert (notif_flowid == flowid_prev)
                    else report_mismatch("notif_flowid", int'(notif_flowid), int'(flowid_prev));
                assert (notif_addr == addr_prev)
                    else report_mismatch("notif_addr", int'(notif_addr), int'(addr_prev));
                assert (notif_len == len_prev)
                    else report_mismatch("notif_len", int'(notif_len), int'(len_prev));
            end
            if (notif_val && notif_rdy) begin
                assert (exp_q.size() != 0) else begin
                    $display("unexpected notification for flow %0d at %0t", notif_flowid, $time);
                    abort_run();
                end
                exp_entry = exp_q.pop_front();
                assert (notif_flowid == exp_entry[26:24])
                    else report_mismatch("notif_flowid", int'(notif_flowid), int'(exp_entry[26:24]));
                assert (notif_addr == exp_entry[23:8])
                    else report_mismatch("notif_addr", int'(notif_addr), int'(exp_entry[23:8]));
                assert (notif_len == exp_entry[7:0])
                    else report_mismatch("notif_len", int'(notif_len), int'(exp_entry[7:0]));
            end
            stall_prev <= notif_val & ~notif_rdy;
            flowid_prev <= notif_flowid;
            addr_prev <= notif_addr;
            len_prev <= notif_len;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        rst = 1'b1;
        {req_val, cfg_val, end_val} = '0;
        notif_rdy = 1'b1;
        {req_flowid, cfg_flowid, end_flowid} = '0;
        {req_len, cfg_base_idx, end_idx} = '0;
        cfg_buf_base = '0;
        waiting_m = '0;
        for (int f = 0; f < num_flows; f++) begin
            {base_m[f], end_m[f], len_m[f]} = '0;
            bufb_m[f] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_all_ready();

        // a single flow that is satisfied when it is posted.
        cur_f = flowid_t'(2);
        cur_base = rand_bits(8);
        cur_len = msg_len_t'(rand_bits(6) + 8'd1);
        configure_flow(cur_f, cur_base, {rand_bits(8), rand_bits(8)});
        write_end(cur_f, ring_idx_t'(cur_base + cur_len + rand_bits(4)));
        post_request(cur_f, cur_len);
        wait_for_drain();

        // short flows that become satisfied once end wraps past 255.
        for (int r = 0; r < 3; r++) begin
            cur_f = flowid_t'(r + 3);
            cur_base = 8'hc0 | rand_bits(6);
            cur_len = 8'h40 | rand_bits(6);
            configure_flow(cur_f, cur_base, {rand_bits(8), rand_bits(8)});
            write_end(cur_f, cur_base);
            post_request(cur_f, cur_len);
            repeat (20) @(negedge clk);
            write_end(cur_f, ring_idx_t'(cur_base + cur_len - 8'd1));
            repeat (20) @(negedge clk);
            write_end(cur_f, ring_idx_t'(cur_base + cur_len + rand_bits(3)));
            wait_for_drain();
        end

        // notification back-pressure, with a repeated post refused meanwhile.
        for (int r = 0; r < 2; r++) begin
            cur_f = flowid_t'(r + 6);
            cur_base = rand_bits(8);
            cur_len = rand_bits(7);
            configure_flow(cur_f, cur_base, {rand_bits(8), rand_bits(8)});
            write_end(cur_f, ring_idx_t'(cur_base + cur_len));
            notif_rdy = 1'b0;
            post_request(cur_f, cur_len);
            while (!notif_val) @(negedge clk);
            span = 2 + int'(rand_bits(4));
            repeat (span) begin
                req_val = 1'b1;
                req_flowid = cur_f;
                #1;
                assert (!req_rdy) else report_mismatch("req_rdy", int'(req_rdy), 0);
                @(negedge clk);
            end
            req_val = 1'b0;
            notif_rdy = 1'b1;
            wait_for_drain();
        end

        // every flow posted in turn, each satisfied up front.
        for (int f = 0; f < num_flows; f++) begin
            cur_base = rand_bits(8);
            post_len[f] = msg_len_t'(rand_bits(7) + 8'd1);
            configure_flow(flowid_t'(f), cur_base, {rand_bits(8), rand_bits(8)});
            write_end(flowid_t'(f), ring_idx_t'(cur_base + post_len[f] + rand_bits(4)));
        end
        for (int f = 0; f < num_flows; f++) begin
            post_request(flowid_t'(f), post_len[f]);
        end
        wait_for_drain();
        check_all_ready();

        $display("test passed");
        $finish;
    end

endmodule
